// File: hdl/dcmp_pkg.sv
/*
 * Decompressor shared definitions
 * Word and byte queue sizes, packet kind codes, decoder state codes
 * and the two views of the three-byte packet header
 */
package dcmp_pkg;

	localparam int DATA_WIDTH = 16;
	localparam int BYTES_PER_WORD = 2;
	localparam int WINDOW_BYTES = 4;
	localparam int QUEUE_BYTES = 6;
	localparam int COUNT_WIDTH = 3;
	localparam int TAKE_WIDTH = 2;
	localparam int LENGTH_WIDTH = 12;

	// Bytes per output word, at queue level and consume widths
	localparam logic [COUNT_WIDTH-1:0] COUNT_WORD = COUNT_WIDTH'(BYTES_PER_WORD);
	localparam logic [TAKE_WIDTH-1:0] TAKE_WORD = TAKE_WIDTH'(BYTES_PER_WORD);

	// Packet kinds from header bits 6:4
	localparam logic [2:0] KIND_ZERO = 3'b000;
	localparam logic [2:0] KIND_FILL = 3'b010;
	localparam logic [2:0] KIND_RAW = 3'b101;
	localparam logic [2:0] KIND_HIGH = 3'b111;

	// Decoder states
	localparam int STATE_WIDTH = 2;
	localparam logic [STATE_WIDTH-1:0] ST_HEADER = 2'd0;
	localparam logic [STATE_WIDTH-1:0] ST_SEND_FILL = 2'd1;
	localparam logic [STATE_WIDTH-1:0] ST_SEND_RAW = 2'd2;

	typedef struct packed {
		logic long_flag;
		logic [2:0] kind;
		logic [3:0] len_low;
	} header_byte_t;

	// Oldest byte sits in the low bits, so the header byte is listed last
	typedef union packed {
		struct packed {
			logic [7:0] unused;
			logic [7:0] value;
			header_byte_t head;
		} short_view;
		struct packed {
			logic [7:0] value;
			logic [7:0] len_high;
			header_byte_t head;
		} long_view;
	} header_u;

endpackage

// File: hdl/byte_window.sv
/*
 * Byte window
 * Splits sink words into bytes held in a small shift queue and shows
 * the oldest bytes to the decoder, which consumes up to three per cycle
 */
`timescale 1ns/10ps

module byte_window (
	input  logic clk,
	input  logic nreset,

	input  logic sink_valid,
	input  logic [dcmp_pkg::DATA_WIDTH-1:0] sink_data,
	output logic sink_ready,

	output logic [dcmp_pkg::WINDOW_BYTES-1:0][7:0] window,
	output logic [dcmp_pkg::COUNT_WIDTH-1:0] fill,
	input  logic [dcmp_pkg::TAKE_WIDTH-1:0] take
);

	logic [dcmp_pkg::QUEUE_BYTES-1:0][7:0] queue;
	logic [dcmp_pkg::QUEUE_BYTES-1:0][7:0] queue_shifted;
	logic [dcmp_pkg::QUEUE_BYTES-1:0][7:0] queue_next;
	logic [dcmp_pkg::COUNT_WIDTH-1:0] level;
	logic [dcmp_pkg::COUNT_WIDTH-1:0] level_rest;
	logic [dcmp_pkg::COUNT_WIDTH-1:0] level_next;
	logic accept;

	assign accept = sink_valid & sink_ready;

	// Bytes left once the decoder has taken its share
	assign level_rest = level - {1'b0, take};
	assign queue_shifted = queue >> {take, 3'b000};

	assign level_next = accept ? level_rest + dcmp_pkg::COUNT_WORD : level_rest;

	// New word lands right behind the remaining bytes, low byte first
	always_comb begin
		for (int i = 0; i < dcmp_pkg::QUEUE_BYTES; i++) begin
			queue_next[i] = queue_shifted[i];
			for (int b = 0; b < dcmp_pkg::BYTES_PER_WORD; b++) begin
				if (accept && i == level_rest + b) begin
					queue_next[i] = sink_data[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		queue <= queue_next;
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			level <= '0;
			sink_ready <= 1'b0;
		end else begin
			level <= level_next;
			// Room for one more whole word next cycle
			sink_ready <= (level_next <= dcmp_pkg::QUEUE_BYTES - dcmp_pkg::BYTES_PER_WORD);
		end
	end

	assign window = queue[dcmp_pkg::WINDOW_BYTES-1:0];
	assign fill = level;

endmodule

// File: hdl/packet_decoder.sv
/*
 * Packet decoder
 * Reads one to three header bytes from the byte window, then offers
 * L+1 output words: copied raw bytes or a repeated fill byte.
 * A length down-counter ends the packet on its last accepted word.
 */
`timescale 1ns/10ps

module packet_decoder (
	input  logic clk,
	input  logic nreset,

	input  logic [dcmp_pkg::WINDOW_BYTES-1:0][7:0] window,
	input  logic [dcmp_pkg::COUNT_WIDTH-1:0] fill,
	output logic [dcmp_pkg::TAKE_WIDTH-1:0] take,

	output logic [dcmp_pkg::DATA_WIDTH-1:0] word,
	output logic word_valid,
	input  logic word_ready
);

	logic [dcmp_pkg::STATE_WIDTH-1:0] state;
	logic [dcmp_pkg::STATE_WIDTH-1:0] state_next;
	logic [dcmp_pkg::LENGTH_WIDTH-1:0] count;
	logic [7:0] fill_value;

	dcmp_pkg::header_u hdr;
	logic long_flag;
	logic [2:0] kind;
	logic is_fill_kind;
	logic [dcmp_pkg::TAKE_WIDTH-1:0] head_size;
	logic head_present;
	logic head_load;
	logic [dcmp_pkg::LENGTH_WIDTH-1:0] head_length;
	logic [7:0] head_value;
	logic [7:0] head_fill;
	logic word_xfer;
	logic last_xfer;

	// Same three bytes, read according to the long flag
	assign hdr = window[2:0];
	assign long_flag = hdr.short_view.head.long_flag;
	assign kind = hdr.short_view.head.kind;
	assign is_fill_kind = (kind == dcmp_pkg::KIND_FILL);

	// One byte, plus one for the long length, plus one for the value byte
	assign head_size = {long_flag | is_fill_kind, ~(long_flag ^ is_fill_kind)};
	assign head_present = (fill >= {1'b0, head_size});
	assign head_load = (state == dcmp_pkg::ST_HEADER) && head_present;

	always_comb begin
		if (long_flag) begin
			head_length = {hdr.long_view.len_high, hdr.long_view.head.len_low};
			head_value = hdr.long_view.value;
		end else begin
			head_length = {8'h00, hdr.short_view.head.len_low};
			head_value = hdr.short_view.value;
		end
	end

	always_comb begin
		case (kind)
			dcmp_pkg::KIND_ZERO: head_fill = 8'h00;
			dcmp_pkg::KIND_HIGH: head_fill = 8'hff;
			dcmp_pkg::KIND_FILL: head_fill = head_value;
			default: head_fill = 8'h00;
		endcase
	end

	// Word offer
	always_comb begin
		word = {fill_value, fill_value};
		word_valid = 1'b0;
		case (state)
			dcmp_pkg::ST_SEND_FILL: begin
				word_valid = 1'b1;
			end
			dcmp_pkg::ST_SEND_RAW: begin
				word = {window[1], window[0]};
				word_valid = (fill >= dcmp_pkg::COUNT_WORD);
			end
			default: begin
				word_valid = 1'b0;
			end
		endcase
	end

	assign word_xfer = word_valid & word_ready;
	assign last_xfer = word_xfer && (count == '0);

	// Bytes consumed from the window this cycle
	always_comb begin
		take = '0;
		if (head_load) begin
			take = head_size;
		end else if (state == dcmp_pkg::ST_SEND_RAW && word_xfer) begin
			take = dcmp_pkg::TAKE_WORD;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			dcmp_pkg::ST_HEADER: begin
				if (head_present) begin
					if (kind == dcmp_pkg::KIND_RAW) begin
						state_next = dcmp_pkg::ST_SEND_RAW;
					end else begin
						state_next = dcmp_pkg::ST_SEND_FILL;
					end
				end
			end
			dcmp_pkg::ST_SEND_FILL, dcmp_pkg::ST_SEND_RAW: begin
				if (last_xfer) begin
					state_next = dcmp_pkg::ST_HEADER;
				end
			end
			default: begin
				state_next = dcmp_pkg::ST_HEADER;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			state <= dcmp_pkg::ST_HEADER;
			count <= '0;
		end else begin
			state <= state_next;
			if (head_load) begin
				count <= head_length;
			end else if (word_xfer) begin
				count <= count - 1'b1;
			end
		end
	end

	// Zero, high and fill packets all repeat one latched byte
	always_ff @(posedge clk) begin
		if (head_load) begin
			fill_value <= head_fill;
		end
	end

endmodule

// File: hdl/word_holder.sv
/*
 * Word holder
 * One-word output register between the decoder and the source port;
 * absorbs source back-pressure at a full word per cycle
 */
`timescale 1ns/10ps

module word_holder (
	input  logic clk,
	input  logic nreset,

	input  logic [dcmp_pkg::DATA_WIDTH-1:0] word,
	input  logic word_valid,
	output logic word_ready,

	output logic source_valid,
	output logic [dcmp_pkg::DATA_WIDTH-1:0] source_data,
	input  logic source_ready
);

	logic hold_valid;
	logic [dcmp_pkg::DATA_WIDTH-1:0] hold_data;

	// Free when empty, or when the held word leaves this cycle
	assign word_ready = ~hold_valid | source_ready;

	always_ff @(posedge clk) begin
		if (!nreset) begin
			hold_valid <= 1'b0;
		end else if (word_valid && word_ready) begin
			hold_valid <= 1'b1;
		end else if (source_ready) begin
			hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (word_valid && word_ready) begin
			hold_data <= word;
		end
	end

	assign source_valid = hold_valid;
	assign source_data = hold_data;

endmodule

// File: hdl/stream_decompressor.sv
/*
 * Stream decompressor top level
 * 16-bit valid/ready sink, byte window, packet decoder and an
 * output holding register on the valid/ready source
 */
`timescale 1ns/10ps

module stream_decompressor (
	input  logic clk,
	input  logic nreset,

	input  logic sink_valid,
	input  logic [dcmp_pkg::DATA_WIDTH-1:0] sink_data,
	output logic sink_ready,

	output logic source_valid,
	output logic [dcmp_pkg::DATA_WIDTH-1:0] source_data,
	input  logic source_ready
);

	// Window link
	logic [dcmp_pkg::WINDOW_BYTES-1:0][7:0] window;
	logic [dcmp_pkg::COUNT_WIDTH-1:0] fill;
	logic [dcmp_pkg::TAKE_WIDTH-1:0] take;

	// Output link
	logic [dcmp_pkg::DATA_WIDTH-1:0] word;
	logic word_valid;
	logic word_ready;

	byte_window u_byte_window (
		.clk(clk),
		.nreset(nreset),
		.sink_valid(sink_valid),
		.sink_data(sink_data),
		.sink_ready(sink_ready),
		.window(window),
		.fill(fill),
		.take(take)
	);

	packet_decoder u_packet_decoder (
		.clk(clk),
		.nreset(nreset),
		.window(window),
		.fill(fill),
		.take(take),
		.word(word),
		.word_valid(word_valid),
		.word_ready(word_ready)
	);

	word_holder u_word_holder (
		.clk(clk),
		.nreset(nreset),
		.word(word),
		.word_valid(word_valid),
		.word_ready(word_ready),
		.source_valid(source_valid),
		.source_data(source_data),
		.source_ready(source_ready)
	);

endmodule

// File: test/dcmp_model.svh
/*
 * Reference model for the stream decompressor
 * Builders append packet bytes to the stimulus byte list; the expander
 * walks that list by the header rule and produces the expected words
 */
`ifndef DCMP_MODEL_SVH
`define DCMP_MODEL_SVH

logic [7:0] stim_bytes[$];
logic [dcmp_pkg::DATA_WIDTH-1:0] exp_words[$];

// Header byte, high length byte for the long form, then value or payload
function automatic void add_packet(input logic [2:0] kind,
		input logic [dcmp_pkg::LENGTH_WIDTH-1:0] length, input bit long_form,
		input logic [7:0] value);
	int n;
	int byte_rand;
	n = int'(length) + 1;
	stim_bytes.push_back({long_form, kind, length[3:0]});
	if (long_form) begin
		stim_bytes.push_back(length[11:4]);
	end
	if (kind == dcmp_pkg::KIND_FILL) begin
		stim_bytes.push_back(value);
	end
	if (kind == dcmp_pkg::KIND_RAW) begin
		for (int k = 0; k < 2 * n; k++) begin
			byte_rand = $urandom;
			stim_bytes.push_back(byte_rand[7:0]);
		end
	end
endfunction

// One-byte zero packet evens out the byte count
function automatic void pad_even();
	if (stim_bytes.size() % 2 != 0) begin
		add_packet(dcmp_pkg::KIND_ZERO, '0, 1'b0, 8'h00);
	end
endfunction

function automatic void expand_packets();
	int i;
	int n;
	logic [7:0] head;
	logic [2:0] kind;
	logic [dcmp_pkg::LENGTH_WIDTH-1:0] length;
	logic [7:0] value;
	i = 0;
	while (i < stim_bytes.size()) begin
		head = stim_bytes[i];
		i++;
		kind = head[6:4];
		length = {8'h00, head[3:0]};
		if (head[7]) begin
			length[11:4] = stim_bytes[i];
			i++;
		end
		n = int'(length) + 1;
		value = 8'h00;
		if (kind == dcmp_pkg::KIND_HIGH) begin
			value = 8'hff;
		end else if (kind == dcmp_pkg::KIND_FILL) begin
			value = stim_bytes[i];
			i++;
		end
		for (int k = 0; k < n; k++) begin
			if (kind == dcmp_pkg::KIND_RAW) begin
				// Low byte first
				exp_words.push_back({stim_bytes[i+1], stim_bytes[i]});
				i += 2;
			end else begin
				exp_words.push_back({value, value});
			end
		end
	end
endfunction

`endif

// File: test/tb_stream_decompressor.sv
/*
 * Testbench for the stream decompressor
 * Builds packet byte streams, feeds them as sink words and checks every
 * source word against the reference model, with and without back-pressure
 */
`timescale 1ns/10ps

module tb_stream_decompressor;

	localparam logic [31:0] SEED = 32'hd50e_7113;
	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DELAY = 1;
	localparam int RANDOM_PACKETS = 40;
	localparam int MAX_LENGTH = 60;
	localparam int TIMEOUT_FACTOR = 20;

	logic clk = 1'b0;
	logic nreset;
	logic sink_valid;
	logic [dcmp_pkg::DATA_WIDTH-1:0] sink_data;
	logic sink_ready;
	logic source_valid;
	logic [dcmp_pkg::DATA_WIDTH-1:0] source_data;
	logic source_ready;

	string test_name = "reset";
	int recv_count = 0;
	int cycle_count = 0;
	int budget_cycles = RESET_CYCLES + 64;
	bit ready_random = 1'b0;

	`include "dcmp_model.svh"

	always #(CLK_PERIOD / 2) clk = ~clk;

	stream_decompressor DUT (
		.clk(clk),
		.nreset(nreset),
		.sink_valid(sink_valid),
		.sink_data(sink_data),
		.sink_ready(sink_ready),
		.source_valid(source_valid),
		.source_data(source_data),
		.source_ready(source_ready)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_word(input string name,
			input logic [dcmp_pkg::DATA_WIDTH-1:0] expected,
			input logic [dcmp_pkg::DATA_WIDTH-1:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR %s: expected word %h, got %h", name, expected, actual));
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			abort_run($sformatf("ERROR %s: expected %0d words, got %0d", name, expected, actual));
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR %s: expected flag %b, got %b", name, expected, actual));
		end
	endtask

	// Source back-pressure is random only in the stress test
	always @(posedge clk) begin
		#DRIVE_DELAY;
		source_ready = ready_random ? ($urandom % 3 != 0) : 1'b1;
	end

	// Every source transfer is counted and compared while expected words remain
	always @(posedge clk) begin
		if (nreset && source_valid && source_ready) begin
			recv_count++;
			if (exp_words.size() != 0) begin
				check_word(test_name, exp_words.pop_front(), source_data);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > budget_cycles) begin
			abort_run($sformatf("Timeout in test %s with %0d words still missing",
				test_name, exp_words.size()));
		end
	end

	function automatic void add_random_packet();
		logic [2:0] kind;
		bit long_form;
		int len_int;
		int value;
		case ($urandom % 4)
			0: kind = dcmp_pkg::KIND_ZERO;
			1: kind = dcmp_pkg::KIND_FILL;
			2: kind = dcmp_pkg::KIND_RAW;
			default: kind = dcmp_pkg::KIND_HIGH;
		endcase
		long_form = ($urandom % 2 == 1);
		len_int = long_form ? $urandom % (MAX_LENGTH + 1) : $urandom % 16;
		value = $urandom;
		add_packet(kind, len_int[dcmp_pkg::LENGTH_WIDTH-1:0], long_form, value[7:0]);
	endfunction

	// Entered and left 1 ns after a rising edge
	task automatic run_test(input string name, input bit stress);
		int n_words;
		int n_exp;
		int idx;
		bit accepted;
		pad_even();
		expand_packets();
		n_exp = exp_words.size();
		n_words = stim_bytes.size() / 2;
		test_name = name;
		recv_count = 0;
		ready_random = stress;
		budget_cycles += TIMEOUT_FACTOR * (n_exp + n_words) + 8;
		idx = 0;
		sink_valid = 1'b0;
		while (idx < n_words) begin
			if (!sink_valid) begin
				sink_valid = !stress || ($urandom % 4 != 0);
			end
			sink_data = {stim_bytes[2*idx+1], stim_bytes[2*idx]};
			@(posedge clk);
			accepted = sink_valid && sink_ready;
			#DRIVE_DELAY;
			if (accepted) begin
				idx++;
				sink_valid = 1'b0;
			end
		end
		while (exp_words.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		#DRIVE_DELAY;
		check_count(name, n_exp, recv_count);
		stim_bytes.delete();
	endtask

	initial begin
		void'($urandom(SEED));
		nreset = 1'b0;
		sink_valid = 1'b0;
		sink_data = '0;
		source_ready = 1'b0;

		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			check_flag("reset", 1'b0, source_valid);
			check_flag("reset", 1'b0, sink_ready);
		end
		nreset = 1'b1;
		// Idle after reset with nothing sent yet
		repeat (4) begin
			@(posedge clk);
			#DRIVE_DELAY;
			check_flag("after reset", 1'b0, source_valid);
			check_flag("after reset", 1'b1, sink_ready);
		end

		add_packet(dcmp_pkg::KIND_RAW, 12'd3, 1'b0, 8'h00);
		run_test("short raw", 1'b0);

		add_packet(dcmp_pkg::KIND_ZERO, 12'd5, 1'b0, 8'h00);
		add_packet(dcmp_pkg::KIND_HIGH, 12'd2, 1'b0, 8'h00);
		run_test("zero and high", 1'b0);

		add_packet(dcmp_pkg::KIND_FILL, 12'd4, 1'b0, 8'h5a);
		add_packet(dcmp_pkg::KIND_FILL, 12'd20, 1'b1, 8'hc3);
		add_packet(dcmp_pkg::KIND_FILL, 12'd0, 1'b1, 8'h81);
		run_test("fill", 1'b0);

		add_packet(dcmp_pkg::KIND_RAW, 12'd300, 1'b1, 8'h00);
		run_test("long raw", 1'b0);

		for (int p = 0; p < RANDOM_PACKETS; p++) begin
			add_random_packet();
		end
		run_test("random", 1'b1);

		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: tb.f
+incdir+test
hdl/dcmp_pkg.sv
hdl/byte_window.sv
hdl/packet_decoder.sv
hdl/word_holder.sv
hdl/stream_decompressor.sv
test/tb_stream_decompressor.sv
